//--- hdl/mempool_consts.svh
////////////////////////////////////////
// Sizes of the TCDM group
// Include wherever the group sizes are needed
////////////////////////////////////////

`ifndef MEMPOOL_CONSTS_SVH
`define MEMPOOL_CONSTS_SVH

// Ports, tiles and banks
`define MEMPOOL_NUM_TILES 4

// Word and byte address widths
`define MEMPOOL_DATA_WIDTH 32
`define MEMPOOL_ADDR_WIDTH 32

// Depth of one bank in words
`define MEMPOOL_BANK_WORDS 256

// Low address bits below the word
`define MEMPOOL_BYTE_OFFSET 2

`endif

//--- hdl/mempool_pkg.sv
////////////////////////////////////////
// Address, data and TCDM request/response types
// Referenced by scoped names from the RTL
////////////////////////////////////////

`default_nettype none

`include "mempool_consts.svh"

package mempool_pkg;

  // Tile, bank or initiator index
  typedef logic [$clog2(`MEMPOOL_NUM_TILES)-1:0] tile_id_t;

  typedef logic [`MEMPOOL_ADDR_WIDTH-1:0]   tcdm_addr_t;
  typedef logic [`MEMPOOL_DATA_WIDTH-1:0]   data_t;
  typedef logic [`MEMPOOL_DATA_WIDTH/8-1:0] strb_t;

  // Word index inside one bank
  typedef logic [$clog2(`MEMPOOL_BANK_WORDS)-1:0] bank_row_t;

  // Request as seen by a bank
  typedef struct packed {
    bank_row_t row;
    tile_id_t  ini_id;
    logic      wen;
    data_t     wdata;
    strb_t     be;
  } tcdm_req_t;

  // Response on its way back to the initiator
  typedef struct packed {
    tile_id_t ini_id;
    data_t    rdata;
  } tcdm_resp_t;

endpackage

`default_nettype wire

//--- hdl/rr_arbiter.sv
////////////////////////////////////////
// Round-robin arbiter over valid/ready inputs
// Grant is held while the output is stalled
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module rr_arbiter #(
  parameter int unsigned NUM_IN    = 4,
  parameter type         payload_t = logic
) (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic     [NUM_IN-1:0] valid_i,
  output logic     [NUM_IN-1:0] ready_o,
  input  payload_t [NUM_IN-1:0] data_i,
  output logic                  valid_o,
  input  logic                  ready_i,
  output payload_t              data_o
);

  localparam int unsigned IDX_W = (NUM_IN > 1) ? $clog2(NUM_IN) : 1;

  logic [IDX_W-1:0] ptr_q;
  logic             lock_q;
  logic [IDX_W-1:0] lock_idx_q;
  logic [IDX_W-1:0] gnt_idx;
  logic             gnt_found;

  always_comb begin
    int unsigned idx;
    idx       = 0;
    gnt_found = 1'b0;
    gnt_idx   = lock_idx_q;
    if (lock_q) begin
      gnt_found = valid_i[lock_idx_q];
    end else begin
      // First valid input at or after the pointer
      for (int unsigned i = 0; i < NUM_IN; i++) begin
        idx = (32'(ptr_q) + i) % NUM_IN;
        if (!gnt_found && valid_i[idx]) begin
          gnt_found = 1'b1;
          gnt_idx   = idx[IDX_W-1:0];
        end
      end
    end
    ready_o = '0;
    if (gnt_found) begin
      ready_o[gnt_idx] = ready_i;
    end
  end

  assign valid_o = gnt_found;
  assign data_o  = data_i[gnt_idx];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ptr_q      <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else if (valid_o && ready_i) begin
      lock_q <= 1'b0;
      ptr_q  <= (gnt_idx == IDX_W'(NUM_IN - 1)) ? '0 : gnt_idx + 1'b1;
    end else if (valid_o) begin
      // Keep this winner while stalled
      lock_q     <= 1'b1;
      lock_idx_q <= gnt_idx;
    end else begin
      lock_q <= 1'b0;
    end
  end

  a_ready_onehot: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) $onehot0(ready_o)
  ) else $error("rr_arbiter: more than one input accepted");

  // Relies on the upstream keeping its valid up
  a_grant_held: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    valid_o && !ready_i |=> valid_o && (gnt_idx == $past(gnt_idx))
  ) else $error("rr_arbiter: grant changed while stalled");

endmodule

`default_nettype wire

//--- hdl/tcdm_req_xbar.sv
////////////////////////////////////////
// Request side of the group interconnect
// Decodes the target tile and arbitrates per bank
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "mempool_consts.svh"

module tcdm_req_xbar (
  input  logic                                                clk_i,
  input  logic                                                arst_n_i,
  input  logic                   [`MEMPOOL_NUM_TILES-1:0]     req_valid_i,
  output logic                   [`MEMPOOL_NUM_TILES-1:0]     req_ready_o,
  input  mempool_pkg::tcdm_addr_t [`MEMPOOL_NUM_TILES-1:0]    req_addr_i,
  input  logic                   [`MEMPOOL_NUM_TILES-1:0]     req_wen_i,
  input  mempool_pkg::data_t     [`MEMPOOL_NUM_TILES-1:0]     req_wdata_i,
  input  mempool_pkg::strb_t     [`MEMPOOL_NUM_TILES-1:0]     req_be_i,
  input  logic                   [`MEMPOOL_NUM_TILES-1:0]     resp_valid_i,
  input  logic                   [`MEMPOOL_NUM_TILES-1:0]     resp_ready_i,
  output logic                   [`MEMPOOL_NUM_TILES-1:0]     bank_req_valid_o,
  input  logic                   [`MEMPOOL_NUM_TILES-1:0]     bank_req_ready_i,
  output mempool_pkg::tcdm_req_t [`MEMPOOL_NUM_TILES-1:0]     bank_req_o
);

  localparam int unsigned NUM_TILES = `MEMPOOL_NUM_TILES;
  localparam int unsigned TILE_W    = $bits(mempool_pkg::tile_id_t);
  localparam int unsigned ROW_W     = $bits(mempool_pkg::bank_row_t);
  localparam int unsigned TILE_LSB  = `MEMPOOL_BYTE_OFFSET;
  localparam int unsigned ROW_LSB   = TILE_LSB + TILE_W;

  mempool_pkg::tile_id_t  [NUM_TILES-1:0] req_tile;
  mempool_pkg::tcdm_req_t [NUM_TILES-1:0] port_req;
  logic                   [NUM_TILES-1:0] out_q;
  logic                   [NUM_TILES-1:0] req_open;
  logic                   [NUM_TILES-1:0] req_fire;
  logic                   [NUM_TILES-1:0] resp_fire;

  // Indexed [bank][port]
  logic [NUM_TILES-1:0][NUM_TILES-1:0] arb_valid;
  logic [NUM_TILES-1:0][NUM_TILES-1:0] arb_ready;

  for (genvar p = 0; p < NUM_TILES; p++) begin : gen_ports
    // Word-interleaved across tiles
    assign req_tile[p] = req_addr_i[p][TILE_LSB +: TILE_W];

    assign port_req[p] = '{
      row:    req_addr_i[p][ROW_LSB +: ROW_W],
      ini_id: mempool_pkg::tile_id_t'(p),
      wen:    req_wen_i[p],
      wdata:  req_wdata_i[p],
      be:     req_be_i[p]
    };

    // One request in flight per port
    assign req_open[p]    = req_valid_i[p] & ~out_q[p];
    assign req_ready_o[p] = ~out_q[p] & (~req_valid_i[p] | arb_ready[req_tile[p]][p]);

    for (genvar b = 0; b < NUM_TILES; b++) begin : gen_route
      assign arb_valid[b][p] = req_open[p] && (req_tile[p] == mempool_pkg::tile_id_t'(b));
    end
  end

  assign req_fire  = req_valid_i & req_ready_o;
  assign resp_fire = resp_valid_i & resp_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      out_q <= '0;
    end else begin
      out_q <= (out_q | req_fire) & ~resp_fire;
    end
  end

  for (genvar b = 0; b < NUM_TILES; b++) begin : gen_banks
    rr_arbiter #(
      .NUM_IN   (NUM_TILES              ),
      .payload_t(mempool_pkg::tcdm_req_t)
    ) i_arb (
      .clk_i   (clk_i              ),
      .arst_n_i(arst_n_i           ),
      .valid_i (arb_valid[b]       ),
      .ready_o (arb_ready[b]       ),
      .data_i  (port_req           ),
      .valid_o (bank_req_valid_o[b]),
      .ready_i (bank_req_ready_i[b]),
      .data_o  (bank_req_o[b]      )
    );
  end

  // Every response must match an accepted request
  a_resp_outstanding: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) (resp_fire & ~out_q) == '0
  ) else $error("tcdm_req_xbar: response without outstanding request");

endmodule

`default_nettype wire

//--- hdl/tcdm_bank.sv
////////////////////////////////////////
// One tile's TCDM bank with a response register
// Writes merge under byte enables
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "mempool_consts.svh"

module tcdm_bank (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  input  mempool_pkg::tcdm_req_t  req_i,
  output logic                    resp_valid_o,
  input  logic                    resp_ready_i,
  output mempool_pkg::tcdm_resp_t resp_o
);

  localparam int unsigned NUM_BYTES = $bits(mempool_pkg::strb_t);

  mempool_pkg::data_t      mem_q [`MEMPOOL_BANK_WORDS];
  mempool_pkg::tcdm_resp_t resp_q;
  logic                    resp_valid_q;
  logic                    req_fire;

  // Accept when empty or draining this cycle
  assign req_ready_o = ~resp_valid_q | resp_ready_i;
  assign req_fire    = req_valid_i & req_ready_o;

  always_ff @(posedge clk_i) begin
    if (req_fire && req_i.wen) begin
      for (int unsigned i = 0; i < NUM_BYTES; i++) begin
        if (req_i.be[i]) begin
          mem_q[req_i.row][8*i +: 8] <= req_i.wdata[8*i +: 8];
        end
      end
    end
  end

  // Writes answer with zero data
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      resp_q.ini_id <= req_i.ini_id;
      resp_q.rdata  <= req_i.wen ? '0 : mem_q[req_i.row];
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      resp_valid_q <= 1'b0;
    end else if (req_fire) begin
      resp_valid_q <= 1'b1;
    end else if (resp_ready_i) begin
      resp_valid_q <= 1'b0;
    end
  end

  assign resp_valid_o = resp_valid_q;
  assign resp_o       = resp_q;

  a_resp_stable: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_o)
  ) else $error("tcdm_bank: response changed while stalled");

endmodule

`default_nettype wire

//--- hdl/tcdm_resp_xbar.sv
////////////////////////////////////////
// Response side of the group interconnect
// Returns bank responses to their initiators
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "mempool_consts.svh"

module tcdm_resp_xbar (
  input  logic                                            clk_i,
  input  logic                                            arst_n_i,
  input  logic                    [`MEMPOOL_NUM_TILES-1:0] bank_resp_valid_i,
  output logic                    [`MEMPOOL_NUM_TILES-1:0] bank_resp_ready_o,
  input  mempool_pkg::tcdm_resp_t [`MEMPOOL_NUM_TILES-1:0] bank_resp_i,
  output logic                    [`MEMPOOL_NUM_TILES-1:0] resp_valid_o,
  input  logic                    [`MEMPOOL_NUM_TILES-1:0] resp_ready_i,
  output mempool_pkg::data_t      [`MEMPOOL_NUM_TILES-1:0] resp_rdata_o
);

  localparam int unsigned NUM_TILES = `MEMPOOL_NUM_TILES;

  // Indexed [port][bank]
  logic [NUM_TILES-1:0][NUM_TILES-1:0] arb_valid;
  logic [NUM_TILES-1:0][NUM_TILES-1:0] arb_ready;

  mempool_pkg::tcdm_resp_t [NUM_TILES-1:0] port_resp;

  for (genvar b = 0; b < NUM_TILES; b++) begin : gen_banks
    for (genvar p = 0; p < NUM_TILES; p++) begin : gen_steer
      assign arb_valid[p][b] = bank_resp_valid_i[b] &&
                               (bank_resp_i[b].ini_id == mempool_pkg::tile_id_t'(p));
    end
    // Only the addressed port can accept
    assign bank_resp_ready_o[b] = arb_ready[bank_resp_i[b].ini_id][b];
  end

  for (genvar p = 0; p < NUM_TILES; p++) begin : gen_ports
    rr_arbiter #(
      .NUM_IN   (NUM_TILES               ),
      .payload_t(mempool_pkg::tcdm_resp_t)
    ) i_arb (
      .clk_i   (clk_i          ),
      .arst_n_i(arst_n_i       ),
      .valid_i (arb_valid[p]   ),
      .ready_o (arb_ready[p]   ),
      .data_i  (bank_resp_i    ),
      .valid_o (resp_valid_o[p]),
      .ready_i (resp_ready_i[p]),
      .data_o  (port_resp[p]   )
    );

    assign resp_rdata_o[p] = port_resp[p].rdata;
  end

endmodule

`default_nettype wire

//--- hdl/mempool_group.sv
////////////////////////////////////////
// Local TCDM of one group, four ports and four banks
// Top level of the design
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "mempool_consts.svh"

module mempool_group (
  input  logic                                             clk_i,
  input  logic                                             arst_n_i,
  // Core-side requests
  input  logic                    [`MEMPOOL_NUM_TILES-1:0] req_valid_i,
  output logic                    [`MEMPOOL_NUM_TILES-1:0] req_ready_o,
  input  mempool_pkg::tcdm_addr_t [`MEMPOOL_NUM_TILES-1:0] req_addr_i,
  input  logic                    [`MEMPOOL_NUM_TILES-1:0] req_wen_i,
  input  mempool_pkg::data_t      [`MEMPOOL_NUM_TILES-1:0] req_wdata_i,
  input  mempool_pkg::strb_t      [`MEMPOOL_NUM_TILES-1:0] req_be_i,
  // Core-side responses
  output logic                    [`MEMPOOL_NUM_TILES-1:0] resp_valid_o,
  input  logic                    [`MEMPOOL_NUM_TILES-1:0] resp_ready_i,
  output mempool_pkg::data_t      [`MEMPOOL_NUM_TILES-1:0] resp_rdata_o
);

  localparam int unsigned NUM_TILES = `MEMPOOL_NUM_TILES;

  logic                    [NUM_TILES-1:0] bank_req_valid;
  logic                    [NUM_TILES-1:0] bank_req_ready;
  mempool_pkg::tcdm_req_t  [NUM_TILES-1:0] bank_req;
  logic                    [NUM_TILES-1:0] bank_resp_valid;
  logic                    [NUM_TILES-1:0] bank_resp_ready;
  mempool_pkg::tcdm_resp_t [NUM_TILES-1:0] bank_resp;

  tcdm_req_xbar i_req_xbar (
    .clk_i           (clk_i         ),
    .arst_n_i        (arst_n_i      ),
    .req_valid_i     (req_valid_i   ),
    .req_ready_o     (req_ready_o   ),
    .req_addr_i      (req_addr_i    ),
    .req_wen_i       (req_wen_i     ),
    .req_wdata_i     (req_wdata_i   ),
    .req_be_i        (req_be_i      ),
    .resp_valid_i    (resp_valid_o  ),
    .resp_ready_i    (resp_ready_i  ),
    .bank_req_valid_o(bank_req_valid),
    .bank_req_ready_i(bank_req_ready),
    .bank_req_o      (bank_req      )
  );

  // One bank per tile
  for (genvar t = 0; t < NUM_TILES; t++) begin : gen_banks
    tcdm_bank i_bank (
      .clk_i       (clk_i             ),
      .arst_n_i    (arst_n_i          ),
      .req_valid_i (bank_req_valid[t] ),
      .req_ready_o (bank_req_ready[t] ),
      .req_i       (bank_req[t]       ),
      .resp_valid_o(bank_resp_valid[t]),
      .resp_ready_i(bank_resp_ready[t]),
      .resp_o      (bank_resp[t]      )
    );
  end

  tcdm_resp_xbar i_resp_xbar (
    .clk_i            (clk_i          ),
    .arst_n_i         (arst_n_i       ),
    .bank_resp_valid_i(bank_resp_valid),
    .bank_resp_ready_o(bank_resp_ready),
    .bank_resp_i      (bank_resp      ),
    .resp_valid_o     (resp_valid_o   ),
    .resp_ready_i     (resp_ready_i   ),
    .resp_rdata_o     (resp_rdata_o   )
  );

endmodule

`default_nettype wire

//--- testbench/tb_mempool_group.sv
////////////////////////////////////////
// Directed tests of the TCDM group top level
// Model follows the word-interleaved address map
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "mempool_consts.svh"

module tb_mempool_group;

  localparam int NUM_TILES      = `MEMPOOL_NUM_TILES;
  localparam int TIMEOUT_CYCLES = 100;

  logic                                    clk;
  logic                                    arst_n;
  logic                    [NUM_TILES-1:0] req_valid;
  logic                    [NUM_TILES-1:0] req_ready;
  mempool_pkg::tcdm_addr_t [NUM_TILES-1:0] req_addr;
  logic                    [NUM_TILES-1:0] req_wen;
  mempool_pkg::data_t      [NUM_TILES-1:0] req_wdata;
  mempool_pkg::strb_t      [NUM_TILES-1:0] req_be;
  logic                    [NUM_TILES-1:0] resp_valid;
  logic                    [NUM_TILES-1:0] resp_ready;
  mempool_pkg::data_t      [NUM_TILES-1:0] resp_rdata;

  mempool_pkg::data_t model [NUM_TILES*`MEMPOOL_BANK_WORDS];
  integer             seed;
  int                 err_count;
  int                 timeout_count;

  mempool_group mempool_group_i (
    .clk_i       (clk       ),
    .arst_n_i    (arst_n    ),
    .req_valid_i (req_valid ),
    .req_ready_o (req_ready ),
    .req_addr_i  (req_addr  ),
    .req_wen_i   (req_wen   ),
    .req_wdata_i (req_wdata ),
    .req_be_i    (req_be    ),
    .resp_valid_o(resp_valid),
    .resp_ready_i(resp_ready),
    .resp_rdata_o(resp_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Bits 3:2 pick the tile, bits 11:4 the row
  function automatic int model_index(input mempool_pkg::tcdm_addr_t addr);
    int tile;
    int row;
    tile = int'(addr[`MEMPOOL_BYTE_OFFSET +: 2]);
    row  = int'(addr[`MEMPOOL_BYTE_OFFSET + 2 +: 8]);
    return row * NUM_TILES + tile;
  endfunction

  function automatic mempool_pkg::tcdm_addr_t make_addr(input int row, input int tile);
    return (mempool_pkg::tcdm_addr_t'(row) << (`MEMPOOL_BYTE_OFFSET + 2)) |
           (mempool_pkg::tcdm_addr_t'(tile) << `MEMPOOL_BYTE_OFFSET);
  endfunction

  function automatic mempool_pkg::data_t merge_bytes(input mempool_pkg::data_t old_w,
                                                     input mempool_pkg::data_t new_w,
                                                     input mempool_pkg::strb_t be);
    mempool_pkg::data_t res;
    res = old_w;
    for (int i = 0; i < $bits(mempool_pkg::strb_t); i++) begin
      if (be[i]) begin
        res[8*i +: 8] = new_w[8*i +: 8];
      end
    end
    return res;
  endfunction

  function automatic mempool_pkg::data_t fill_pattern(input mempool_pkg::tcdm_addr_t addr);
    return addr ^ {addr[15:0], addr[31:16]} ^ 32'h5a3c_96e1;
  endfunction

  task automatic check_data(input string name, input mempool_pkg::data_t actual,
                            input mempool_pkg::data_t expected);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, actual, expected);
      err_count++;
    end
  endtask

  task automatic check_flag(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, actual, expected);
      err_count++;
    end
  endtask

  // Called and returns 2 ns after a rising edge
  task automatic send_req(input int p, input mempool_pkg::tcdm_addr_t addr, input logic wen,
                          input mempool_pkg::data_t wdata, input mempool_pkg::strb_t be,
                          output bit ok);
    int cnt;
    req_valid[p] = 1'b1;
    req_addr[p]  = addr;
    req_wen[p]   = wen;
    req_wdata[p] = wdata;
    req_be[p]    = be;
    cnt = 0;
    @(negedge clk);
    while (!req_ready[p] && cnt < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cnt++;
    end
    ok = req_ready[p];
    if (!ok) begin
      $display("Timeout at %0t: port %0d never accepted its request", $time, p);
      timeout_count++;
    end
    @(posedge clk);
    #2;
    req_valid[p] = 1'b0;
  endtask

  task automatic wait_resp_valid(input int p, output bit ok);
    int cnt;
    cnt = 0;
    @(negedge clk);
    while (!resp_valid[p] && cnt < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cnt++;
    end
    ok = resp_valid[p];
    if (!ok) begin
      $display("Timeout at %0t: port %0d got no response", $time, p);
      timeout_count++;
    end
  endtask

  task automatic recv_resp(input int p, output mempool_pkg::data_t rdata, output bit ok);
    rdata = '0;
    wait_resp_valid(p, ok);
    if (ok) begin
      rdata = resp_rdata[p];
      @(posedge clk);
      #2;
    end
  endtask

  task automatic do_access(input int p, input mempool_pkg::tcdm_addr_t addr, input logic wen,
                           input mempool_pkg::data_t wdata, input mempool_pkg::strb_t be,
                           output mempool_pkg::data_t rdata, output bit ok);
    bit sent;
    rdata = '0;
    ok    = 1'b0;
    send_req(p, addr, wen, wdata, be, sent);
    if (sent) begin
      recv_resp(p, rdata, ok);
    end
  endtask

  task automatic write_word(input int p, input mempool_pkg::tcdm_addr_t addr,
                            input mempool_pkg::data_t wdata, input mempool_pkg::strb_t be);
    mempool_pkg::data_t ack;
    bit                 ok;
    do_access(p, addr, 1'b1, wdata, be, ack, ok);
    if (ok) begin
      check_data($sformatf("resp_rdata_o[%0d] write ack", p), ack, '0);
      model[model_index(addr)] = merge_bytes(model[model_index(addr)], wdata, be);
    end
  endtask

  task automatic read_check(input int p, input mempool_pkg::tcdm_addr_t addr);
    mempool_pkg::data_t rdata;
    bit                 ok;
    do_access(p, addr, 1'b0, '0, '0, rdata, ok);
    if (ok) begin
      check_data($sformatf("resp_rdata_o[%0d]", p), rdata, model[model_index(addr)]);
    end
  endtask

  task automatic test_reset_and_basic();
    @(negedge clk);
    for (int p = 0; p < NUM_TILES; p++) begin
      check_flag($sformatf("req_ready_o[%0d]", p), req_ready[p], 1'b1);
      check_flag($sformatf("resp_valid_o[%0d]", p), resp_valid[p], 1'b0);
    end
    @(posedge clk);
    #2;
    write_word(0, 32'h0000_0100, 32'hcafe_0123, '1);
    read_check(0, 32'h0000_0100);
  endtask

  task automatic test_byte_enables();
    write_word(2, 32'h0000_0204, 32'h1122_3344, '1);
    write_word(2, 32'h0000_0204, 32'haabb_ccdd, 4'b0101);
    read_check(2, 32'h0000_0204);
  endtask

  task automatic test_shared_memory();
    for (int i = 0; i < 8; i++) begin
      write_word(0, 32'h0000_0400 + 32'(4 * i), $random(seed), '1);
    end
    for (int p = 1; p < NUM_TILES; p++) begin
      for (int i = 0; i < 8; i++) begin
        read_check(p, 32'h0000_0400 + 32'(4 * i));
      end
    end
  endtask

  // Every port targets tile 2
  task automatic test_bank_contention();
    fork
      write_word(0, make_addr(20, 2), $random(seed), '1);
      write_word(1, make_addr(21, 2), $random(seed), '1);
      write_word(2, make_addr(22, 2), $random(seed), '1);
      write_word(3, make_addr(23, 2), $random(seed), '1);
    join
    for (int p = 0; p < NUM_TILES; p++) begin
      read_check(p, make_addr(20 + p, 2));
    end
  endtask

  task automatic test_backpressure();
    mempool_pkg::data_t held;
    mempool_pkg::data_t rdata;
    bit                 ok;
    resp_ready[1] = 1'b0;
    send_req(1, 32'h0000_0408, 1'b0, '0, '0, ok);
    if (ok) begin
      wait_resp_valid(1, ok);
    end
    if (ok) begin
      held = resp_rdata[1];
      check_data("resp_rdata_o[1]", held, model[model_index(32'h0000_0408)]);
      repeat (5) begin
        @(negedge clk);
        check_flag("resp_valid_o[1]", resp_valid[1], 1'b1);
        check_data("resp_rdata_o[1]", resp_rdata[1], held);
        check_flag("req_ready_o[1]", req_ready[1], 1'b0);
      end
      @(posedge clk);
      #2;
      resp_ready[1] = 1'b1;
      recv_resp(1, rdata, ok);
      check_data("resp_rdata_o[1]", rdata, held);
      @(negedge clk);
      check_flag("req_ready_o[1]", req_ready[1], 1'b1);
      @(posedge clk);
      #2;
    end
    resp_ready[1] = 1'b1;
  endtask

  // Each port owns rows 32..47 with row % 4 equal to its index
  task automatic random_port_ops(input int p);
    logic [31:0]             rnd;
    mempool_pkg::tcdm_addr_t addr;
    for (int i = 0; i < 16; i++) begin
      addr = make_addr(32 + 4 * (i / 4) + p, i % 4);
      write_word(p, addr, fill_pattern(addr), '1);
    end
    for (int n = 0; n < 24; n++) begin
      rnd  = $random(seed);
      addr = make_addr(32 + 4 * int'(rnd[11:10]) + p, int'(rnd[9:8]));
      if (rnd[0]) begin
        write_word(p, addr, $random(seed), rnd[7:4]);
      end else begin
        read_check(p, addr);
      end
    end
  endtask

  task automatic test_random_mix();
    fork
      random_port_ops(0);
      random_port_ops(1);
      random_port_ops(2);
      random_port_ops(3);
    join
  endtask

  initial begin
    seed          = 32'h347c_3731;
    err_count     = 0;
    timeout_count = 0;
    arst_n        = 1'b0;
    req_valid     = '0;
    req_addr      = '0;
    req_wen       = '0;
    req_wdata     = '0;
    req_be        = '0;
    resp_ready    = '1;
    repeat (10) @(posedge clk);
    #2;
    arst_n = 1'b1;

    test_reset_and_basic();
    test_byte_enables();
    test_shared_memory();
    test_bank_contention();
    test_backpressure();
    test_random_mix();

    $display("Done: %0d check errors, %0d timeouts", err_count, timeout_count);
    if (err_count == 0 && timeout_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
+incdir+hdl
hdl/mempool_pkg.sv
hdl/rr_arbiter.sv
hdl/tcdm_req_xbar.sv
hdl/tcdm_bank.sv
hdl/tcdm_resp_xbar.sv
hdl/mempool_group.sv
testbench/tb_mempool_group.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_mempool_group
FILELIST  := sim.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(wildcard hdl/*.sv hdl/*.svh testbench/*.sv)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
